//--- logic/fpAddPkg.sv
package fpAddPkg;
	// Half-precision format
	localparam int EXP_W    = 5;
	localparam int MAN_W    = 10;                 // Stored fraction
	localparam int SIG_W    = MAN_W + 1;          // Fraction plus hidden bit
	localparam int EXP_BIAS = 15;
	localparam int GRS_W    = 3;                  // Guard, round, sticky
	localparam int SUM_W    = SIG_W + GRS_W + 1;  // One extra bit for the carry out

	localparam logic [15:0] QNAN = 16'h7E00;     // Canonical quiet NaN

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp_e;

	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] frac;
	} fp16_t;

	// Exception flags with no divide-by-zero for an adder
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} fpFlags_t;

	// Special-case override decided up front and applied at packing
	typedef struct packed {
		logic forceNan;
		logic forceInf;
		logic infSign;  // Sign of the infinity to emit
	} fpClass_t;

	typedef struct packed {
		logic             valid;
		logic             effSub;    // Magnitudes are subtracted
		logic             sign;      // Sign of the larger operand
		logic [EXP_W-1:0] exp;       // Larger exponent
		logic [SIG_W-1:0] sigL;      // Larger significand
		logic [SIG_W-1:0] sigS;      // Smaller significand before alignment
		logic [EXP_W-1:0] shift;     // Exponent gap
		logic             bothZero;
		fpClass_t         cls;
	} preStage_t;

	typedef struct packed {
		logic                   valid;
		logic                   effSub;
		logic                   sign;
		logic [EXP_W-1:0]       exp;
		logic [SIG_W-1:0]       sigL;
		logic [SIG_W+GRS_W-1:0] sigS;  // Aligned with GRS in the low bits
		logic                   bothZero;
		fpClass_t               cls;
	} alignStage_t;

	typedef struct packed {
		logic             valid;
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [SUM_W-1:0] sum;  // Carry, significand, GRS
		logic             bothZero;
		fpClass_t         cls;
	} sumStage_t;

	typedef struct packed {
		logic                    valid;
		logic                    sign;
		logic signed [EXP_W+1:0] exp;  // Can go below 1 or above 30
		logic [SIG_W-1:0]        sig;  // Leading one at the top
		logic                    guard;
		logic                    round;
		logic                    sticky;
		logic                    zeroSum;
		fpClass_t                cls;
	} normStage_t;
endpackage

//--- logic/fpPrealign.sv
module fpPrealign import fpAddPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ce,
	input  logic      inValid,
	input  fp16_t     a,
	input  fp16_t     b,
	input  fpOp_e     op,
	output preStage_t pre
);
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	logic                   signB;  // b sign with the opcode folded in
	logic                   aZero;  // Zero or subnormal read as zero
	logic                   bZero;
	logic                   aNan;
	logic                   bNan;
	logic                   aInf;
	logic                   bInf;
	logic [EXP_W+MAN_W-1:0] aMag;
	logic [EXP_W+MAN_W-1:0] bMag;
	logic                   aLarger;
	logic [EXP_W:0]         expDiff;  // Extra bit catches a wrong ordering
	preStage_t              preNext;

	assign signB = b.sign ^ (op == opSub);  // a - b is a + (-b)
	assign aZero = (a.exp == '0);
	assign bZero = (b.exp == '0);
	assign aNan  = (a.exp == EXP_MAX) && (a.frac != '0);
	assign bNan  = (b.exp == EXP_MAX) && (b.frac != '0);
	assign aInf  = (a.exp == EXP_MAX) && (a.frac == '0);
	assign bInf  = (b.exp == EXP_MAX) && (b.frac == '0);

	// Flushed magnitudes compare as plain integers
	assign aMag    = aZero ? '0 : {a.exp, a.frac};
	assign bMag    = bZero ? '0 : {b.exp, b.frac};
	assign aLarger = (aMag >= bMag);

	always_comb begin
		preNext.valid    = inValid;
		preNext.effSub   = a.sign ^ signB;
		preNext.bothZero = aZero && bZero;
		if (aLarger) begin
			preNext.sign = a.sign;
			preNext.exp  = a.exp;
			preNext.sigL = {~aZero, aMag[MAN_W-1:0]};  // Hidden bit only for normals
			preNext.sigS = {~bZero, bMag[MAN_W-1:0]};
			expDiff      = {1'b0, a.exp} - {1'b0, b.exp};
		end else begin
			preNext.sign = signB;
			preNext.exp  = b.exp;
			preNext.sigL = {~bZero, bMag[MAN_W-1:0]};
			preNext.sigS = {~aZero, aMag[MAN_W-1:0]};
			expDiff      = {1'b0, b.exp} - {1'b0, a.exp};
		end
		preNext.shift = expDiff[EXP_W-1:0];
		if (preNext.bothZero && preNext.effSub)
			preNext.sign = 1'b0;  // (+0) + (-0) is +0
		preNext.cls.forceNan = aNan || bNan || (aInf && bInf && preNext.effSub);
		preNext.cls.forceInf = (aInf || bInf) && !preNext.cls.forceNan;
		preNext.cls.infSign  = aInf ? a.sign : signB;
	end

	always_ff @(posedge clk) begin
		if (ce) pre <= preNext;
		if (rst) pre.valid <= 1'b0;
	end

	// Swap must always put the larger exponent on top
	shiftNonNeg: assert property (@(posedge clk) disable iff (rst)
		(ce && inValid) |-> !expDiff[EXP_W])
		else $error("prealign produced a negative exponent gap");
endmodule

//--- logic/fpAlign.sv
module fpAlign import fpAddPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        ce,
	input  preStage_t   pre,
	output alignStage_t aln
);
	localparam int ALN_W = SIG_W + GRS_W;  // Significand plus GRS

	logic [ALN_W-1:0] base;    // Smaller significand with empty GRS
	logic [3:0]       coarse;  // 0, 4, 8 or 12
	logic [ALN_W-1:0] lvl1;
	logic [ALN_W-1:0] lvl2;
	logic             lost1;   // Bits dropped by the coarse level
	logic             lost2;
	alignStage_t      alnNext;

	assign base = {pre.sigS, {GRS_W{1'b0}}};

	always_comb begin
		// Coarse level in steps of four
		coarse  = {pre.shift[3:2], 2'b00};
		lvl1    = base >> coarse;
		lost1   = |(base & ~({ALN_W{1'b1}} << coarse));
		lvl1[0] = lvl1[0] | lost1;  // Fold into sticky
		// Fine level of 0 to 3
		lvl2    = lvl1 >> pre.shift[1:0];
		lost2   = |(lvl1 & ~({ALN_W{1'b1}} << pre.shift[1:0]));
		lvl2[0] = lvl2[0] | lost2;
		// Whole significand falls below sticky
		if (pre.shift >= EXP_W'(ALN_W))
			lvl2 = {{(ALN_W-1){1'b0}}, |pre.sigS};
	end

	always_comb begin
		alnNext.valid    = pre.valid;
		alnNext.effSub   = pre.effSub;
		alnNext.sign     = pre.sign;
		alnNext.exp      = pre.exp;
		alnNext.sigL     = pre.sigL;
		alnNext.sigS     = lvl2;
		alnNext.bothZero = pre.bothZero;
		alnNext.cls      = pre.cls;
	end

	always_ff @(posedge clk) begin
		if (ce) aln <= alnNext;
		if (rst) aln.valid <= 1'b0;
	end
endmodule

//--- logic/fpMantAdd.sv
module fpMantAdd import fpAddPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        ce,
	input  alignStage_t aln,
	output sumStage_t   sum
);
	logic [SUM_W-1:0] opL;  // Larger with zero GRS and carry headroom
	logic [SUM_W-1:0] opS;  // Aligned smaller
	sumStage_t        sumNext;

	assign opL = {1'b0, aln.sigL, {GRS_W{1'b0}}};
	assign opS = {1'b0, aln.sigS};

	always_comb begin
		sumNext.valid    = aln.valid;
		sumNext.sign     = aln.sign;  // Larger operand sets the sign
		sumNext.exp      = aln.exp;
		sumNext.bothZero = aln.bothZero;
		sumNext.cls      = aln.cls;
		if (aln.effSub)
			sumNext.sum = opL - opS;  // Sticky LSB keeps the borrow right
		else
			sumNext.sum = opL + opS;
	end

	always_ff @(posedge clk) begin
		if (ce) sum <= sumNext;
		if (rst) sum.valid <= 1'b0;
	end

	// Ordering from prealign means a difference never wraps
	diffNonNeg: assert property (@(posedge clk) disable iff (rst)
		(ce && aln.valid && aln.effSub) |-> !sumNext.sum[SUM_W-1])
		else $error("significand difference went negative");
endmodule

//--- logic/fpNormalize.sv
module fpNormalize import fpAddPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ce,
	input  sumStage_t  sum,
	output normStage_t nrm
);
	logic                    carry;   // Sum spilled into the top bit
	logic [SUM_W-2:0]        body;    // Sum below the carry
	logic [3:0]              lz;      // Leading zeros in body
	logic [SUM_W-2:0]        shl;
	logic signed [EXP_W+1:0] expIn;
	normStage_t              nrmNext;

	assign carry = sum.sum[SUM_W-1];
	assign body  = sum.sum[SUM_W-2:0];
	assign expIn = $signed({2'b00, sum.exp});

	// Priority encoder where the highest set bit wins
	always_comb begin
		lz = 4'(SUM_W - 2);
		for (int i = 0; i < SUM_W - 1; i++)
			if (body[i]) lz = 4'(SUM_W - 2 - i);
	end

	assign shl = body << lz;  // Leading one to the top

	always_comb begin
		nrmNext.valid   = sum.valid;
		nrmNext.cls     = sum.cls;
		nrmNext.zeroSum = (sum.sum == '0);
		// Exact zero stays negative only for (-0) + (-0)
		nrmNext.sign = sum.sign && (!nrmNext.zeroSum || sum.bothZero);
		if (carry) begin
			// One step right with the lowest two bits folded into sticky
			nrmNext.exp    = expIn + 7'sd1;
			nrmNext.sig    = sum.sum[SUM_W-1:GRS_W+1];
			nrmNext.guard  = sum.sum[GRS_W];
			nrmNext.round  = sum.sum[GRS_W-1];
			nrmNext.sticky = |sum.sum[GRS_W-2:0];
		end else begin
			nrmNext.exp    = expIn - $signed({3'b000, lz});  // May go below 1
			nrmNext.sig    = shl[SUM_W-2:GRS_W];
			nrmNext.guard  = shl[GRS_W-1];
			nrmNext.round  = shl[GRS_W-2];
			nrmNext.sticky = shl[GRS_W-3];
		end
	end

	always_ff @(posedge clk) begin
		if (ce) nrm <= nrmNext;
		if (rst) nrm.valid <= 1'b0;
	end

	// Any nonzero sum must leave here normalized
	leadOne: assert property (@(posedge clk) disable iff (rst)
		(nrm.valid && !nrm.zeroSum) |-> nrm.sig[SIG_W-1])
		else $error("normalized significand lost its leading one");
endmodule

//--- logic/fpRound.sv
module fpRound import fpAddPkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ce,
	input  normStage_t nrm,
	output logic       outValid,
	output fp16_t      result,
	output fpFlags_t   flags
);
	localparam logic [EXP_W-1:0]        EXP_MAX = '1;  // Inf and NaN exponent
	localparam logic signed [EXP_W+1:0] EXP_TOP = 7'(2 * EXP_BIAS);  // Largest finite

	logic                    roundUp;
	logic [SIG_W:0]          sigRnd;   // One bit up for the rounding carry
	logic signed [EXP_W+1:0] expRnd;
	logic                    inexact;
	fp16_t                   resNext;
	fpFlags_t                flagsNext;

	// Ties go up only from an odd significand
	assign roundUp = nrm.guard && (nrm.round || nrm.sticky || nrm.sig[0]);
	assign sigRnd  = {1'b0, nrm.sig} + {{SIG_W{1'b0}}, roundUp};
	assign expRnd  = nrm.exp + $signed({{(EXP_W+1){1'b0}}, sigRnd[SIG_W]});  // Renormalize
	assign inexact = nrm.guard || nrm.round || nrm.sticky;

	always_comb begin
		// On a rounding carry the fraction is all zero either way
		resNext.sign      = nrm.sign;
		resNext.exp       = expRnd[EXP_W-1:0];
		resNext.frac      = sigRnd[MAN_W-1:0];
		flagsNext         = '0;
		flagsNext.inexact = inexact;
		if (nrm.cls.forceNan) begin
			resNext           = QNAN;
			flagsNext         = '0;
			flagsNext.invalid = 1'b1;
		end else if (nrm.cls.forceInf) begin
			resNext.sign = nrm.cls.infSign;  // Exact so no flags raised
			resNext.exp  = EXP_MAX;
			resNext.frac = '0;
			flagsNext    = '0;
		end else if (nrm.zeroSum) begin
			resNext.exp  = '0;
			resNext.frac = '0;
			flagsNext    = '0;
		end else if (expRnd > EXP_TOP) begin
			resNext.exp        = EXP_MAX;  // Signed infinity
			resNext.frac       = '0;
			flagsNext.overflow = 1'b1;
			flagsNext.inexact  = 1'b1;
		end else if (expRnd < 7'sd1) begin
			resNext.exp         = '0;  // Flush since subnormals are never produced
			resNext.frac        = '0;
			flagsNext.underflow = 1'b1;
			flagsNext.inexact   = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			outValid <= nrm.valid;
			result   <= resNext;
			flags    <= flagsNext;
		end
		if (rst) outValid <= 1'b0;
	end
endmodule

//--- logic/fpAddSubTop.sv
module fpAddSubTop import fpAddPkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     ce,        // Low freezes every stage
	input  logic     inValid,
	input  fp16_t    a,
	input  fp16_t    b,
	input  fpOp_e    op,
	output logic     outValid,
	output fp16_t    result,
	output fpFlags_t flags
);
	preStage_t   pre;  // Classified and ordered
	alignStage_t aln;  // Smaller significand aligned
	sumStage_t   sum;  // Raw sum or difference
	normStage_t  nrm;  // Leading one at the top

	fpPrealign i_fpPrealign (
		.clk     (clk),
		.rst     (rst),
		.ce      (ce),
		.inValid (inValid),
		.a       (a),
		.b       (b),
		.op      (op),
		.pre     (pre)
	);

	fpAlign i_fpAlign (
		.clk (clk),
		.rst (rst),
		.ce  (ce),
		.pre (pre),
		.aln (aln)
	);

	fpMantAdd i_fpMantAdd (
		.clk (clk),
		.rst (rst),
		.ce  (ce),
		.aln (aln),
		.sum (sum)
	);

	fpNormalize i_fpNormalize (
		.clk (clk),
		.rst (rst),
		.ce  (ce),
		.sum (sum),
		.nrm (nrm)
	);

	fpRound i_fpRound (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.nrm      (nrm),
		.outValid (outValid),
		.result   (result),
		.flags    (flags)
	);
endmodule

//--- tests/fpAddSubTb.sv
module fpAddSubTb import fpAddPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NCORNER = 25;
	localparam int NRANDOM = 500;
	localparam int NVEC    = NCORNER + NRANDOM;
	localparam int LATENCY = 5;  // Enabled edges from accept to the edge that pops

	typedef struct packed {
		fp16_t    res;
		fpFlags_t flags;
	} expect_t;

	typedef struct packed {
		fp16_t       a;
		fp16_t       b;
		fpOp_e       op;
		expect_t     want;
		logic [31:0] acceptEdge;  // Enabled-edge index of the accept
	} pending_t;

	logic     clk;
	logic     rst;
	logic     ce;
	logic     inValid;
	fp16_t    a;
	fp16_t    b;
	fpOp_e    op;
	logic     outValid;
	fp16_t    result;
	fpFlags_t flags;

	logic [31:0] lfsr = 32'h2aab_7a00;
	logic [31:0] enEdges = '0;  // Counts edges with ce high
	pending_t    pending [$];
	int          errors = 0;
	int          checked = 0;

	fpAddSubTop i_fpAddSubTop (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.inValid  (inValid),
		.a        (a),
		.b        (b),
		.op       (op),
		.outValid (outValid),
		.result   (result),
		.flags    (flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois form with taps 32 30 26 25
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};  // One step per bit
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	// Exact sum in units of 2^-24 rounded to nearest even
	function automatic expect_t fpAddRef(input fp16_t x, input fp16_t y, input fpOp_e o);
		expect_t r;
		logic    sy;  // y sign after the opcode
		logic    xNan;
		logic    yNan;
		logic    xInf;
		logic    yInf;
		longint  vx;
		longint  vy;
		longint  s;
		longint  mag;
		longint  kept;
		longint  rem;
		longint  half;
		int      p;
		int      e;
		r    = '0;
		rem  = 0;
		sy   = y.sign ^ (o == opSub);
		xNan = (x.exp == 5'h1F) && (x.frac != 0);
		yNan = (y.exp == 5'h1F) && (y.frac != 0);
		xInf = (x.exp == 5'h1F) && (x.frac == 0);
		yInf = (y.exp == 5'h1F) && (y.frac == 0);
		if (xNan || yNan || (xInf && yInf && (x.sign != sy))) begin
			r.res           = QNAN;
			r.flags.invalid = 1'b1;
			return r;
		end
		if (xInf || yInf) begin
			r.res = {(xInf ? x.sign : sy), 5'h1F, 10'h000};
			return r;
		end
		vx = (x.exp == 0) ? 0 : longint'({1'b1, x.frac}) << (int'(x.exp) - 1);  // Subnormal is 0
		vy = (y.exp == 0) ? 0 : longint'({1'b1, y.frac}) << (int'(y.exp) - 1);
		if (x.sign) vx = -vx;
		if (sy) vy = -vy;
		s = vx + vy;
		if (s == 0) begin
			r.res.sign = (x.exp == 0) && (y.exp == 0) && x.sign && sy;  // Only -0 plus -0
			return r;
		end
		r.res.sign = (s < 0);
		mag        = (s < 0) ? -s : s;
		p          = 0;
		for (int i = 0; i < 64; i++)
			if (mag[i]) p = i;
		e = p - 9;  // Biased exponent of the leading one
		if (p > 10) begin
			kept = mag >> (p - 10);
			rem  = mag & ((longint'(1) << (p - 10)) - 1);
			half = longint'(1) << (p - 11);
			if ((rem > half) || ((rem == half) && kept[0]))
				kept++;
		end else
			kept = mag << (10 - p);  // Exact
		if (kept == 2048) begin
			kept = 1024;  // Rounding carry
			e++;
		end
		if (e > 30) begin
			r.res.exp      = 5'h1F;
			r.flags        = 4'b1001;  // Overflow, inexact
		end else if (e < 1) begin
			r.res.exp      = '0;       // Flush to signed zero
			r.flags        = 4'b0101;  // Underflow, inexact
		end else begin
			r.res.exp      = e[4:0];
			r.res.frac     = kept[9:0];
			r.flags.inexact = (rem != 0);
		end
		return r;
	endfunction

	// Directed pairs as {a, b, op}
	function automatic logic [32:0] cornerPair(input int idx);
		case (idx)
			0:  return {16'h3C00, 16'h3C00, opAdd};  // 1 + 1
			1:  return {16'h3C00, 16'h1000, opAdd};  // Tie that stays even
			2:  return {16'h3C01, 16'h1000, opAdd};  // Tie where odd goes up
			3:  return {16'h3FFF, 16'h1000, opAdd};  // Rounding carry into exponent
			4:  return {16'h3C00, 16'h1001, opAdd};  // Just over half
			5:  return {16'h7BFF, 16'h7BFF, opAdd};  // Overflow
			6:  return {16'h7BFF, 16'h4C00, opAdd};  // Overflow by rounding
			7:  return {16'h0401, 16'h0400, opSub};  // Positive underflow flush
			8:  return {16'h0400, 16'h0401, opSub};  // Negative underflow flush
			9:  return {16'h0001, 16'h3C00, opAdd};  // Subnormal reads as zero
			10: return {16'h8001, 16'h8000, opAdd};
			11: return {16'h03FF, 16'h83FF, opAdd};
			12: return {16'h8000, 16'h8000, opAdd};
			13: return {16'h0000, 16'h0000, opSub};
			14: return {16'h8000, 16'h0000, opSub};
			15: return {16'h7E00, 16'h3C00, opAdd};  // NaN in
			16: return {16'h3C00, 16'h7C01, opAdd};
			17: return {16'h7C00, 16'h7C00, opSub};  // Inf minus inf
			18: return {16'h7C00, 16'hFC00, opAdd};
			19: return {16'h7C00, 16'h7C00, opAdd};
			20: return {16'hFC00, 16'h3C00, opAdd};  // Inf plus finite
			21: return {16'h3C00, 16'h7C00, opSub};
			22: return {16'h3C01, 16'h3C00, opSub};  // Cancellation
			23: return {16'h4500, 16'h4500, opSub};
			default: return {16'h3C00, 16'h0400, opAdd};  // Huge gap leaves sticky only
		endcase
	endfunction

	task automatic randomOperands(output fp16_t x, output fp16_t y, output fpOp_e o);
		logic [1:0] mode;
		x    = 16'(randBits(16));
		mode = 2'(randBits(2));
		if (mode[1] == 1'b0)
			y = 16'(randBits(16));
		else if (mode == 2'd2) begin
			y.sign = 1'(randBits(1));
			y.exp  = x.exp ^ 5'(randBits(2));  // Close exponents
			y.frac = 10'(randBits(10));
		end else begin
			y.sign = 1'(randBits(1));
			y.exp  = x.exp;
			y.frac = x.frac ^ 10'(randBits(3));  // Near-total cancellation
		end
		o = fpOp_e'(randBits(1));
	endtask

	// Holds the pair until it lands on an enabled edge
	task automatic presentVector(input fp16_t x, input fp16_t y, input fpOp_e o,
		input logic stalls);
		logic     accepted;
		pending_t item;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			a  = x;
			b  = y;
			op = o;
			ce = stalls ? (randBits(2) != 0) : 1'b1;
			if (ce && (!stalls || (randBits(3) != 0))) begin
				inValid         = 1'b1;
				accepted        = 1'b1;
				item.a          = x;
				item.b          = y;
				item.op         = o;
				item.want       = fpAddRef(x, y, o);
				item.acceptEdge = enEdges + 1;  // The coming edge
				pending.push_back(item);
			end else
				inValid = ce ? 1'b0 : 1'(randBits(1));  // Valid while frozen must be ignored
		end
	endtask

	task automatic checkResult(input fp16_t got, input fp16_t want, input pending_t item);
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t: result %h, expected %h for %h %s %h", $time, got, want,
				item.a, (item.op == opSub) ? "-" : "+", item.b);
		end
	endtask

	task automatic checkFlags(input fpFlags_t got, input fpFlags_t want, input pending_t item);
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t: flags %b, expected %b for %h %s %h", $time, got, want,
				item.a, (item.op == opSub) ? "-" : "+", item.b);
		end
	endtask

	// Pops one expected entry per result consumed on an enabled edge
	always @(posedge clk) begin
		pending_t item;
		if (ce && !rst) begin
			enEdges++;
			if (outValid === 1'b1) begin
				if (pending.size() == 0) begin
					errors++;
					$display("Output at %0t with no operation pending", $time);
				end else begin
					item = pending.pop_front();
					checked++;
					checkResult(result, item.want.res, item);
					checkFlags(flags, item.want.flags, item);
					if (enEdges - item.acceptEdge != LATENCY) begin
						errors++;
						$display("[ERROR] %0t: latency %0d enabled edges, expected %0d",
							$time, enEdges - item.acceptEdge, LATENCY);
					end
				end
			end
		end
	end

	initial begin
		fp16_t x;
		fp16_t y;
		fpOp_e o;
		logic [32:0] pair;
		int drainLeft;
		rst     = 1'b1;
		ce      = 1'b0;
		inValid = 1'b0;
		a       = '0;
		b       = '0;
		op      = opAdd;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		if (outValid !== 1'b0) begin
			errors++;
			$display("outValid was not low after reset");
		end
		for (int n = 0; n < NVEC; n++) begin
			if (n < NCORNER) begin
				pair = cornerPair(n);
				x    = pair[32:17];
				y    = pair[16:1];
				o    = fpOp_e'(pair[0]);
			end else
				randomOperands(x, y, o);
			presentVector(x, y, o, (n >= NCORNER));  // Corners run with ce held high
		end
		@(negedge clk);
		inValid = 1'b0;
		ce      = 1'b1;
		drainLeft = 2 * LATENCY;  // Last result is due LATENCY edges after its accept
		while ((pending.size() != 0) && (drainLeft > 0)) begin
			@(negedge clk);
			drainLeft--;
		end
		repeat (10) @(negedge clk);  // Catch any extra output
		if (pending.size() != 0) begin
			errors++;
			$display("%0d results never came out", pending.size());
		end
		$display("Checked %0d results, %0d errors", checked, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Four cycles per vector covers stalls, gaps and the drain
	initial begin
		#(NVEC * 4 * 10 + 200);
		$display("Timeout, the pipeline stopped delivering results");
		$display("RESULT: FAIL");
		$finish;
	end
endmodule

//--- files.f
logic/fpAddPkg.sv
logic/fpPrealign.sv
logic/fpAlign.sv
logic/fpMantAdd.sv
logic/fpNormalize.sv
logic/fpRound.sv
logic/fpAddSubTop.sv
tests/fpAddSubTb.sv
